// ==== logic/id_stack.sv ====
`default_nettype none

`include "id_tracker_macros.svh"

module id_stack (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issued,
    input  logic                 retired,
    input  logic                 store_committed,
    input  id_tracker_pkg::id_t  retired_id,
    input  id_tracker_pkg::id_t  store_id,
    input  logic [`ID_DEPTH-1:0] shift_bits,
    input  logic [`ID_DEPTH-1:0] store_shift_bits,
    output id_tracker_pkg::id_t  ordering [`ID_DEPTH-1:0],
    output id_tracker_pkg::id_t  ordering_post_store [`ID_DEPTH-1:0],
    output logic                 id_available,
    output logic                 empty,
    output id_tracker_pkg::id_t  next_id
);

    // ordered pool
    // positions at or below the pointer are free, above are in flight
    // higher position means older id
    id_tracker_pkg::id_t stack [`ID_DEPTH-1:0];
    id_tracker_pkg::id_t store_shift_in [`ID_DEPTH-1:0];
    id_tracker_pkg::id_t post_store [`ID_DEPTH-1:0];
    id_tracker_pkg::id_t retire_shift_in [`ID_DEPTH-1:0];
    id_tracker_pkg::id_t new_stack [`ID_DEPTH-1:0];

    id_tracker_pkg::ptr_t free_ptr;

    ////////////////////////////////////////////////////////////////////////////
    // two-stage shift

    always_comb begin
        // stage one is the store commit
        // returned id enters at the bottom, masked entries move up one
        store_shift_in[0] = store_id;
        for (int i = 1; i < `ID_DEPTH; i++) begin
            store_shift_in[i] = stack[i-1];
        end
        for (int i = 0; i < `ID_DEPTH; i++) begin
            if (store_committed && store_shift_bits[i]) begin
                post_store[i] = store_shift_in[i];
            end else begin
                post_store[i] = stack[i];
            end
        end
    end

    always_comb begin
        // stage two is the retirement
        // works on the post-store order
        retire_shift_in[0] = retired_id;
        for (int i = 1; i < `ID_DEPTH; i++) begin
            retire_shift_in[i] = post_store[i-1];
        end
        for (int i = 0; i < `ID_DEPTH; i++) begin
            if (retired && shift_bits[i]) begin
                new_stack[i] = retire_shift_in[i];
            end else begin
                new_stack[i] = post_store[i];
            end
        end
    end

    // identity order on reset
    // so the first ids out are known
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ID_DEPTH; i++) begin
                stack[i] <= id_tracker_pkg::id_t'(i);
            end
        end else begin
            stack <= new_stack;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // free pointer

    // starts at the top entry
    // drops below zero in the low bits once the last id goes out
    always_ff @(posedge clk) begin
        if (rst) begin
            free_ptr <= '1;
        end else begin
            free_ptr <= free_ptr + id_tracker_pkg::ptr_t'(retired)
                      + id_tracker_pkg::ptr_t'(store_committed)
                      - id_tracker_pkg::ptr_t'(issued);
        end
    end

    assign next_id      = stack[free_ptr[`ID_W-1:0]];
    assign id_available = free_ptr[`ID_W];
    // all ones means every id sits in the free region
    assign empty        = &free_ptr;

    assign ordering            = stack;
    assign ordering_post_store = post_store;

endmodule

`default_nettype wire

// ==== logic/id_tracker_macros.svh ====
`ifndef ID_TRACKER_MACROS_SVH
`define ID_TRACKER_MACROS_SVH

// number of instruction ids in the pool
`define ID_DEPTH 8

// bits needed to name one id
`define ID_W ($clog2(`ID_DEPTH))

`endif

// ==== logic/id_tracker_pkg.sv ====
`default_nettype none

`include "id_tracker_macros.svh"

package id_tracker_pkg;

    // one instruction id
    typedef logic [`ID_W-1:0] id_t;

    // free pointer with one extra bit on top
    // top bit high while at least one id is free
    typedef logic [`ID_W:0] ptr_t;

    // four-phase req/ack handshake
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACK,
        HS_WAIT_LOW
    } hs_state_t;

endpackage

`default_nettype wire

// ==== logic/id_tracker_top.sv ====
`default_nettype none

`include "id_tracker_macros.svh"

module id_tracker_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_req,
    input  logic                retire_req,
    input  logic                store_req,
    input  id_tracker_pkg::id_t retire_id,
    input  id_tracker_pkg::id_t store_id,
    output logic                issue_ack,
    output logic                retire_ack,
    output logic                store_ack,
    output logic                id_available,
    output logic                empty,
    output id_tracker_pkg::id_t issue_id,
    output id_tracker_pkg::id_t oldest_id
);

    // one-cycle pulses from the ports
    logic issued;
    logic retired;
    logic store_committed;

    // ids held by the release ports
    id_tracker_pkg::id_t retired_id;
    id_tracker_pkg::id_t store_release_id;

    id_tracker_pkg::id_t next_id;
    id_tracker_pkg::id_t ordering [`ID_DEPTH-1:0];
    id_tracker_pkg::id_t ordering_post_store [`ID_DEPTH-1:0];

    logic [`ID_DEPTH-1:0] store_shift_bits;
    logic [`ID_DEPTH-1:0] shift_bits;

    ////////////////////////////////////////////////////////////////////////////
    // handshake ports

    issue_port issue_port0 (
        .clk          (clk),
        .rst          (rst),
        .issue_req    (issue_req),
        .id_available (id_available),
        .next_id      (next_id),
        .issue_ack    (issue_ack),
        .issued       (issued),
        .issue_id     (issue_id)
    );

    // retire from write-back
    release_port retire_port0 (
        .clk           (clk),
        .rst           (rst),
        .req           (retire_req),
        .req_id        (retire_id),
        .ack           (retire_ack),
        .release_pulse (retired),
        .release_id    (retired_id)
    );

    // committed stores
    release_port store_port0 (
        .clk           (clk),
        .rst           (rst),
        .req           (store_req),
        .req_id        (store_id),
        .ack           (store_ack),
        .release_pulse (store_committed),
        .release_id    (store_release_id)
    );

    ////////////////////////////////////////////////////////////////////////////
    // shift masks and stack

    // store mask on the current order
    shift_mask_gen store_mask0 (
        .ordering (ordering),
        .id       (store_release_id),
        .mask     (store_shift_bits)
    );

    // retire mask on the order after the store shift
    shift_mask_gen retire_mask0 (
        .ordering (ordering_post_store),
        .id       (retired_id),
        .mask     (shift_bits)
    );

    id_stack id_stack0 (
        .clk                 (clk),
        .rst                 (rst),
        .issued              (issued),
        .retired             (retired),
        .store_committed     (store_committed),
        .retired_id          (retired_id),
        .store_id            (store_release_id),
        .shift_bits          (shift_bits),
        .store_shift_bits    (store_shift_bits),
        .ordering            (ordering),
        .ordering_post_store (ordering_post_store),
        .id_available        (id_available),
        .empty               (empty),
        .next_id             (next_id)
    );

    // top position holds the oldest in-flight id
    assign oldest_id = ordering[`ID_DEPTH-1];

endmodule

`default_nettype wire

// ==== logic/issue_port.sv ====
`default_nettype none

module issue_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_req,
    input  logic                id_available,
    input  id_tracker_pkg::id_t next_id,
    output logic                issue_ack,
    output logic                issued,
    output id_tracker_pkg::id_t issue_id
);

    id_tracker_pkg::hs_state_t state;
    id_tracker_pkg::hs_state_t state_next;

    // request accepted this cycle
    logic take;

    // no free id keeps the request waiting in idle
    assign take = (state == id_tracker_pkg::HS_IDLE) && issue_req && id_available;

    ////////////////////////////////////////////////////////////////////////////
    // handshake FSM

    always_comb begin
        state_next = state;
        unique case (state)
            id_tracker_pkg::HS_IDLE: begin
                if (take) begin
                    state_next = id_tracker_pkg::HS_ACK;
                end
            end
            id_tracker_pkg::HS_ACK: begin
                // req may already be gone
                if (issue_req) begin
                    state_next = id_tracker_pkg::HS_WAIT_LOW;
                end else begin
                    state_next = id_tracker_pkg::HS_IDLE;
                end
            end
            id_tracker_pkg::HS_WAIT_LOW: begin
                if (!issue_req) begin
                    state_next = id_tracker_pkg::HS_IDLE;
                end
            end
            default: state_next = id_tracker_pkg::HS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= id_tracker_pkg::HS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // id held for the whole ack phase
    always_ff @(posedge clk) begin
        if (take) begin
            issue_id <= next_id;
        end
    end

    // pulse only in the first ack cycle
    assign issued    = (state == id_tracker_pkg::HS_ACK);
    assign issue_ack = (state != id_tracker_pkg::HS_IDLE);

endmodule

`default_nettype wire

// ==== logic/release_port.sv ====
`default_nettype none

module release_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  id_tracker_pkg::id_t req_id,
    output logic                ack,
    output logic                release_pulse,
    output id_tracker_pkg::id_t release_id
);

    id_tracker_pkg::hs_state_t state;
    id_tracker_pkg::hs_state_t state_next;

    // no back-pressure so any request in idle is taken
    logic take;

    assign take = (state == id_tracker_pkg::HS_IDLE) && req;

    always_comb begin
        state_next = state;
        unique case (state)
            id_tracker_pkg::HS_IDLE: begin
                if (take) begin
                    state_next = id_tracker_pkg::HS_ACK;
                end
            end
            id_tracker_pkg::HS_ACK: begin
                if (req) begin
                    state_next = id_tracker_pkg::HS_WAIT_LOW;
                end else begin
                    state_next = id_tracker_pkg::HS_IDLE;
                end
            end
            id_tracker_pkg::HS_WAIT_LOW: begin
                // hold ack until the env lets go
                if (!req) begin
                    state_next = id_tracker_pkg::HS_IDLE;
                end
            end
            default: state_next = id_tracker_pkg::HS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= id_tracker_pkg::HS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // captured on the rising request
    always_ff @(posedge clk) begin
        if (take) begin
            release_id <= req_id;
        end
    end

    assign release_pulse = (state == id_tracker_pkg::HS_ACK);
    assign ack           = (state != id_tracker_pkg::HS_IDLE);

endmodule

`default_nettype wire

// ==== logic/shift_mask_gen.sv ====
`default_nettype none

`include "id_tracker_macros.svh"

module shift_mask_gen (
    input  id_tracker_pkg::id_t  ordering [`ID_DEPTH-1:0],
    input  id_tracker_pkg::id_t  id,
    output logic [`ID_DEPTH-1:0] mask
);

    // one-hot position of id in the ordering
    logic [`ID_DEPTH-1:0] match;

    always_comb begin
        for (int i = 0; i < `ID_DEPTH; i++) begin
            match[i] = (ordering[i] == id);
        end
    end

    // mask covers the match and everything below it
    // scan from the top and keep the bit once set
    always_comb begin
        logic hit;
        hit = 1'b0;
        for (int i = `ID_DEPTH - 1; i >= 0; i--) begin
            hit     = hit | match[i];
            mask[i] = hit;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 -Mdir obj_dir --top-module id_tracker_tb -f verilog.f \
    && ./obj_dir/Vid_tracker_tb \
    || { echo "build or simulation failed" >&2; exit 1; }

// ==== test/id_tracker_properties.sv ====
`default_nettype none

`include "id_tracker_macros.svh"

module id_stack_properties (
    input  logic                clk,
    input  logic                rst,
    input  logic                issued,
    input  logic                id_available,
    input  id_tracker_pkg::id_t ordering [`ID_DEPTH-1:0],
    input  id_tracker_pkg::ptr_t free_ptr
);

    // high while no id appears twice in the pool
    logic distinct;

    always_comb begin
        distinct = 1'b1;
        for (int i = 0; i < `ID_DEPTH; i++) begin
            for (int j = i + 1; j < `ID_DEPTH; j++) begin
                if (ordering[i] == ordering[j]) begin
                    distinct = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stack invariants

    a_distinct: assert property (@(posedge clk) disable iff (rst) distinct)
        else $error("ordering holds the same id at two positions");

    // valid range runs from no id free up to all ids free
    a_ptr_range: assert property (@(posedge clk) disable iff (rst)
        free_ptr[`ID_W] || (&free_ptr[`ID_W-1:0]))
        else $error("free pointer moved out of its range");

    // an issue pulse only ever takes a free id
    a_issue_free: assert property (@(posedge clk) disable iff (rst) issued |-> id_available)
        else $error("issue pulse while no id was free");

endmodule

bind id_stack id_stack_properties props0 (
    .clk          (clk),
    .rst          (rst),
    .issued       (issued),
    .id_available (id_available),
    .ordering     (stack),
    .free_ptr     (free_ptr)
);

`default_nettype wire

// ==== test/id_tracker_tb.sv ====
`default_nettype none

`include "id_tracker_macros.svh"

module id_tracker_tb;

    localparam int DEPTH        = `ID_DEPTH;
    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 16;
    localparam int STEPS        = 600;
    // longest step is the wait on a full pool plus one release
    localparam int STEP_CYCLES  = 10;
    localparam int ACK_LIMIT    = 8;
    // random steps plus the directed fill and full-pool wait
    localparam int WATCHDOG_TIME =
        (RESET_CYCLES + (STEPS + 2 * DEPTH) * STEP_CYCLES) * PERIOD;

    logic clk;
    logic rst;
    logic issue_req;
    logic retire_req;
    logic store_req;
    logic issue_ack;
    logic retire_ack;
    logic store_ack;
    logic id_available;
    logic empty;
    id_tracker_pkg::id_t retire_id;
    id_tracker_pkg::id_t store_id;
    id_tracker_pkg::id_t issue_id;
    id_tracker_pkg::id_t oldest_id;

    // reference model
    // in-flight ids in issue order, head is the oldest
    id_tracker_pkg::id_t inflight_q [$];
    // free ids in the order they go out
    id_tracker_pkg::id_t free_q [$];
    logic [31:0] lfsr_state;

    id_tracker_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .issue_req    (issue_req),
        .retire_req   (retire_req),
        .store_req    (store_req),
        .retire_id    (retire_id),
        .store_id     (store_id),
        .issue_ack    (issue_ack),
        .retire_ack   (retire_ack),
        .store_ack    (store_ack),
        .id_available (id_available),
        .empty        (empty),
        .issue_id     (issue_id),
        .oldest_id    (oldest_id)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // error reporting and random bits

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic flag_mismatch(input string msg);
        abort_run($sformatf("MISMATCH t=%0t %s", $time, msg));
    endtask

    task automatic flag_error(input string msg);
        abort_run($sformatf("ERROR t=%0t %s", $time, msg));
    endtask

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return val;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // model and status checks

    task automatic return_to_pool(input id_tracker_pkg::id_t id);
        for (int k = 0; k < inflight_q.size(); k++) begin
            if (inflight_q[k] == id) begin
                inflight_q.delete(k);
                break;
            end
        end
        // lands at position 0, the far end of the free region
        free_q.push_back(id);
    endtask

    task automatic check_status();
        assert (empty == (inflight_q.size() == 0))
            else flag_mismatch($sformatf("empty=%0b with %0d ids in flight",
                                         empty, inflight_q.size()));
        assert (id_available == (inflight_q.size() < DEPTH))
            else flag_mismatch($sformatf("id_available=%0b with %0d ids in flight",
                                         id_available, inflight_q.size()));
        if (!empty) begin
            assert (oldest_id == inflight_q[0])
                else flag_mismatch($sformatf("oldest_id=%0d expected %0d",
                                             oldest_id, inflight_q[0]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // handshakes

    // issue_req already high
    task automatic finish_issue(input logic check_latency);
        id_tracker_pkg::id_t expect_id;
        int waited;
        int hold;
        waited = 0;
        while (!issue_ack) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                flag_error("issue_ack never came for a pending request");
            end
        end
        if (check_latency) begin
            assert (waited == 1)
                else flag_mismatch($sformatf("issue ack after %0d cycles", waited));
        end
        expect_id = free_q[0];
        assert (issue_id == expect_id)
            else flag_mismatch($sformatf("issue_id=%0d expected %0d", issue_id, expect_id));
        foreach (inflight_q[k]) begin
            assert (inflight_q[k] != issue_id)
                else flag_mismatch($sformatf("issued id %0d is already in flight", issue_id));
        end
        hold = rand_bits(1);
        repeat (hold) @(negedge clk);
        issue_req = 1'b0;
        waited = 0;
        while (issue_ack) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                flag_error("issue_ack stayed high after issue_req fell");
            end
        end
        expect_id = free_q.pop_front();
        inflight_q.push_back(expect_id);
        check_status();
    endtask

    task automatic issue_one();
        issue_req = 1'b1;
        finish_issue(1'b1);
    endtask

    task automatic release_ids(input logic do_retire, input id_tracker_pkg::id_t r_id,
                               input logic do_store, input id_tracker_pkg::id_t s_id);
        int hold;
        int waited;
        if (do_retire) begin
            retire_id  = r_id;
            retire_req = 1'b1;
        end
        if (do_store) begin
            store_id  = s_id;
            store_req = 1'b1;
        end
        // release latency is fixed at one cycle
        @(negedge clk);
        assert (retire_ack == do_retire)
            else flag_mismatch($sformatf("retire_ack=%0b one cycle after request", retire_ack));
        assert (store_ack == do_store)
            else flag_mismatch($sformatf("store_ack=%0b one cycle after request", store_ack));
        hold = rand_bits(1);
        repeat (hold) @(negedge clk);
        retire_req = 1'b0;
        store_req  = 1'b0;
        waited = 0;
        while (retire_ack || store_ack) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                flag_error("release ack stayed high after its request fell");
            end
        end
        // store shift first, retirement lands below it
        if (do_store) begin
            return_to_pool(s_id);
        end
        if (do_retire) begin
            return_to_pool(r_id);
        end
        check_status();
    endtask

    // pool full, request has to wait for a release
    task automatic issue_while_full();
        id_tracker_pkg::id_t returned;
        issue_req = 1'b1;
        repeat (2) begin
            @(negedge clk);
            assert (!issue_ack && !id_available)
                else flag_mismatch("issue acked while no id was free");
        end
        returned = inflight_q[rand_bits(3) % inflight_q.size()];
        release_ids(1'b1, returned, 1'b0, '0);
        finish_issue(1'b0);
        // only free id so it goes straight back out
        assert (issue_id == returned)
            else flag_mismatch($sformatf("returned id %0d not issued next, got %0d",
                                         returned, issue_id));
    endtask

    task automatic run_step(input int issue_cut);
        int n;
        int kind;
        int i;
        int j;
        n = inflight_q.size();
        if (n == 0 || rand_bits(3) < issue_cut) begin
            if (n == DEPTH) begin
                issue_while_full();
            end else begin
                issue_one();
            end
        end else begin
            kind = rand_bits(2) % 3;
            i = rand_bits(3) % n;
            if (kind == 2 && n >= 2) begin
                j = (i + 1 + rand_bits(3) % (n - 1)) % n;
                release_ids(1'b1, inflight_q[i], 1'b1, inflight_q[j]);
            end else if (kind == 1) begin
                release_ids(1'b0, '0, 1'b1, inflight_q[i]);
            end else begin
                release_ids(1'b1, inflight_q[i], 1'b0, '0);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // port timing

    a_retire_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(retire_req) |=> retire_ack)
        else flag_mismatch("retire_ack not one cycle after retire_req");

    a_store_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(store_req) |=> store_ack)
        else flag_mismatch("store_ack not one cycle after store_req");

    a_issue_hold: assert property (@(posedge clk) disable iff (rst)
        issue_ack && issue_req |=> issue_ack)
        else flag_mismatch("issue_ack fell while issue_req was high");

    initial begin
        #(WATCHDOG_TIME);
        flag_error("watchdog expired before the test steps finished");
    end

    initial begin
        lfsr_state = 32'h39fd_1c6b;
        rst        = 1'b1;
        issue_req  = 1'b0;
        retire_req = 1'b0;
        store_req  = 1'b0;
        retire_id  = '0;
        store_id   = '0;
        // identity order, top position goes out first
        for (int k = DEPTH - 1; k >= 0; k--) begin
            free_q.push_back(id_tracker_pkg::id_t'(k));
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        assert (!issue_ack && !retire_ack && !store_ack)
            else flag_mismatch("ack high after reset");
        assert (id_available && empty)
            else flag_mismatch($sformatf("after reset id_available=%0b empty=%0b",
                                         id_available, empty));

        // fill the pool in reset order
        for (int k = 0; k < DEPTH; k++) begin
            issue_one();
            assert (issue_id == id_tracker_pkg::id_t'(DEPTH - 1 - k))
                else flag_mismatch($sformatf("fill issue %0d gave id %0d", k, issue_id));
        end
        issue_while_full();

        for (int step = 0; step < STEPS; step++) begin
            // fill and drain phases of a hundred steps
            run_step(((step / 100) % 2 == 0) ? 5 : 2);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
logic/id_tracker_pkg.sv
logic/shift_mask_gen.sv
logic/issue_port.sv
logic/release_port.sv
logic/id_stack.sv
logic/id_tracker_top.sv
test/id_tracker_properties.sv
test/id_tracker_tb.sv
